// ==== logic/colmix_pkg.sv ====
// palette fixed at 512 x 12 bit, 3 layers; layer bank and enable encodings are fixed here
`default_nettype none

package colmix_pkg;

    localparam int PAL_AW      = 9;               // palette index width
    localparam int CPU_AW      = 10;              // cpu bus, bit 9 picks the half
    localparam int CPU_SEL_BIT = PAL_AW;          // 0: green/red byte, 1: blue nibble
    localparam int PRIO_AW     = 8;               // priority PROM depth 256
    localparam int COL_W       = 4;               // bits per gun
    localparam int CODE_W      = 7;               // layer color code
    localparam int BANK_W      = PAL_AW - CODE_W; // palette bank select

    // layer enable bit positions
    localparam int EN_CHAR = 0;
    localparam int EN_SCR  = 1;
    localparam int EN_OBJ  = 2;

    typedef logic [7:0]        cpu_byte_t;
    typedef logic [PAL_AW-1:0] pal_addr_t; // {bank, code}
    typedef logic [BANK_W-1:0] bank_t;

    localparam bank_t BANK_CHAR = 2'd0;
    localparam bank_t BANK_OBJ  = 2'd1;
    localparam bank_t BANK_SCR  = 2'd2;

    // g:r is the cpu byte (g upper nibble), b sits alone in the other half
    typedef struct packed {
        logic [COL_W-1:0] b;
        logic [COL_W-1:0] g;
        logic [COL_W-1:0] r;
    } color_t;

    // PROM result, both low codes pick char
    typedef enum logic [1:0] {
        LAYER_CHAR     = 2'd0,
        LAYER_CHAR_ALT = 2'd1,
        LAYER_OBJ      = 2'd2,
        LAYER_SCR      = 2'd3
    } layer_e;

    // PROM address, msb first
    typedef struct packed {
        logic       scr_hi;     // scroll bit 7
        logic       obj_hi;     // obj bit 7
        logic       obj_blank;
        logic       char_blank;
        logic [3:0] scr_lo;     // scroll bits 3..0
    } prio_sel_t;

endpackage

`default_nettype wire

// ==== logic/pal_lookup_if.sv ====
// lookup path only; color is undefined while the cpu owns the palette
`timescale 1ns/1ns
`default_nettype none

interface pal_lookup_if import colmix_pkg::*; ();

    pal_addr_t lookup_addr; // winning layer's palette index
    logic      lookup_step; // new index this clk
    color_t    color;       // palette read data
    logic      color_step;  // color valid for the index stepped a clk ago

    modport producer (
        output lookup_addr,
        output lookup_step
    );

    modport buffer (
        input  lookup_addr,
        input  lookup_step,
        output color,
        output color_step
    );

    modport consumer (
        input  color,
        input  color_step
    );

endinterface

`default_nettype wire

// ==== logic/sync_ram.sv ====
// single port, read-before-write, one clk read latency, contents undefined at power up
`timescale 1ns/1ns
`default_nettype none

module sync_ram #(
    parameter type word_t = logic [7:0], // payload
    parameter int  AW     = 8            // address width
) (
    input  wire logic          clk,
    input  wire logic          we,
    input  wire logic [AW-1:0] addr,
    input  wire word_t         wdata,
    output      word_t         rdata
);

    localparam int DEPTH = 2 ** AW;

    word_t mem [DEPTH]; // no reset on storage

    // read every clk, old data on a write
    always_ff @(posedge clk) begin
        if (we) begin
            mem[addr] <= wdata;
        end
        rdata <= mem[addr]; // registered read
    end

endmodule

`default_nettype wire

// ==== logic/layer_priority.sv ====
// pxl_cen at most one clk in two; pixel stream is undefined while prom_we is high
`timescale 1ns/1ns
`default_nettype none

module layer_priority import colmix_pkg::*; (
    input  wire logic                 clk,
    input  wire logic                 rst_n,
    input  wire logic                 pxl_cen,
    input  wire logic [CODE_W-1:0]    char_pxl,
    input  wire logic [7:0]           obj_pxl,
    input  wire logic [7:0]           scr_pxl,
    input  wire logic [2:0]           layer_en,  // char, scroll, obj
    input  wire logic [PRIO_AW-1:0]   prog_addr,
    input  wire logic [1:0]           prom_din,
    input  wire logic                 prom_we,
    pal_lookup_if.producer            lk
);

    logic               char_blank;
    logic               obj_blank;
    logic [7:0]         scr_gated;
    prio_sel_t          sel;
    prio_sel_t          sel_q;
    logic [CODE_W-1:0]  char_q;
    logic [CODE_W-1:0]  obj_q;
    logic [CODE_W-1:0]  scr_q;
    logic [PRIO_AW-1:0] prom_addr;
    layer_e             prio;

    // blank when disabled or transparent color
    assign char_blank = ~layer_en[EN_CHAR] | ~|char_pxl[3:0];
    assign obj_blank  = ~layer_en[EN_OBJ]  | ~|obj_pxl[3:0];
    assign scr_gated  = scr_pxl & {8{layer_en[EN_SCR]}}; // disabled scroll reads 0

    always_comb begin
        sel            = '0;
        sel.scr_hi     = scr_gated[7];
        sel.obj_hi     = obj_pxl[7];
        sel.obj_blank  = obj_blank;
        sel.char_blank = char_blank;
        sel.scr_lo     = scr_gated[3:0];
    end

    // stage 1, pixels and PROM address
    always_ff @(posedge clk) begin
        if (pxl_cen) begin
            sel_q  <= sel;
            char_q <= char_pxl;
            obj_q  <= obj_pxl[CODE_W-1:0];
            scr_q  <= scr_gated[CODE_W-1:0];
        end
    end

    // programming port wins over lookup
    assign prom_addr = prom_we ? prog_addr : PRIO_AW'(sel_q);

    sync_ram #(
        .word_t (layer_e),
        .AW     (PRIO_AW)
    ) u_prom (
        .clk    (clk),
        .we     (prom_we),
        .addr   (prom_addr),
        .wdata  (layer_e'(prom_din)),
        .rdata  (prio)           // valid a clk after sel_q, before next tick
    );

    // stage 2, palette index from the winner
    always_ff @(posedge clk) begin
        if (pxl_cen) begin
            case (prio)
                LAYER_OBJ:      lk.lookup_addr <= {BANK_OBJ, obj_q};
                LAYER_SCR:      lk.lookup_addr <= {BANK_SCR, scr_q};
                LAYER_CHAR,
                LAYER_CHAR_ALT: lk.lookup_addr <= {BANK_CHAR, char_q};
                default:        lk.lookup_addr <= {BANK_CHAR, char_q}; // unprogrammed PROM
            endcase
        end
    end

    // marks the clk right after a new index
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            lk.lookup_step <= 1'b0;
        end else begin
            lk.lookup_step <= pxl_cen;
        end
    end

endmodule

`default_nettype wire

// ==== logic/palette_store.sv ====
// cpu holds pal_cs and address at least 4 clk; pixel colors undefined while pal_cs is high
`timescale 1ns/1ns
`default_nettype none

module palette_store import colmix_pkg::*; (
    input  wire logic              clk,
    input  wire logic              rst_n,
    input  wire logic              pal_cs,
    input  wire logic              cpu_wr_n,
    input  wire logic [CPU_AW-1:0] cpu_addr,
    input  wire cpu_byte_t         cpu_din,
    output      cpu_byte_t         pal_dout,
    pal_lookup_if.buffer           lk
);

    logic              cs_q;    // cpu owns the RAM address
    logic              cs_qq;   // read data belongs to the cpu address
    logic              wr_q;
    logic [CPU_AW-1:0] addr_q;
    cpu_byte_t         din_q;
    pal_addr_t         ram_addr;
    logic              ram_we;
    color_t            ram_q;
    color_t            merged;

    // cpu strobe, control part
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            cs_q  <= 1'b0;
            cs_qq <= 1'b0;
            wr_q  <= 1'b0;
        end else begin
            cs_q  <= pal_cs;
            cs_qq <= cs_q;
            wr_q  <= pal_cs & ~cpu_wr_n;
        end
    end

    // cpu address and data
    always_ff @(posedge clk) begin
        addr_q <= cpu_addr;
        din_q  <= cpu_din;
    end

    // cpu overrides the pixel lookup
    assign ram_addr = cs_q ? addr_q[PAL_AW-1:0] : lk.lookup_addr;

    // read-modify-write, only the addressed half changes
    always_comb begin
        merged = ram_q;
        if (addr_q[CPU_SEL_BIT]) begin
            merged.b = din_q[COL_W-1:0];
        end else begin
            merged.g = din_q[7:4];
            merged.r = din_q[3:0];
        end
    end

    assign ram_we = wr_q & cs_qq; // wait for the entry read back

    sync_ram #(
        .word_t (color_t),
        .AW     (PAL_AW)
    ) u_pal (
        .clk    (clk),
        .we     (ram_we),
        .addr   (ram_addr),
        .wdata  (merged),
        .rdata  (ram_q)
    );

    // readback, blue half padded with ones
    always_ff @(posedge clk) begin
        if (addr_q[CPU_SEL_BIT]) begin
            pal_dout <= {{(8 - COL_W){1'b1}}, ram_q.b};
        end else begin
            pal_dout <= {ram_q.g, ram_q.r};
        end
    end

    assign lk.color = ram_q; // straight from the RAM register

    // no step while the cpu held the address
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            lk.color_step <= 1'b0;
        end else begin
            lk.color_step <= lk.lookup_step & ~cs_q;
        end
    end

endmodule

`default_nettype wire

// ==== logic/color_output.sv ====
// BLANK_STAGES must equal the pixel stages ahead of this block; last color held over cpu access
`timescale 1ns/1ns
`default_nettype none

module color_output import colmix_pkg::*; #(
    parameter int BLANK_STAGES = 3
) (
    input  wire logic             clk,
    input  wire logic             rst_n,
    input  wire logic             pxl_cen,
    input  wire logic             vbl,
    input  wire logic             hbl,
    output      logic             lvbl_dly,
    output      logic             lhbl_dly,
    output      logic [COL_W-1:0] red,
    output      logic [COL_W-1:0] green,
    output      logic [COL_W-1:0] blue,
    pal_lookup_if.consumer        lk
);

    logic [BLANK_STAGES-1:0][1:0] blank_sh; // {lvbl, lhbl}, active low
    logic [1:0]                   blank_end;
    logic                         bl;
    logic                         fresh;    // color arrived since last tick
    color_t                       col_q;

    assign blank_end = blank_sh[BLANK_STAGES-1];
    assign bl        = ~&blank_end; // either blank low

    // blank delay line, starts in blanking
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            blank_sh <= '0;
        end else if (pxl_cen) begin
            blank_sh[0] <= ~{vbl, hbl};
            for (int i = 1; i < BLANK_STAGES; i++) begin
                blank_sh[i] <= blank_sh[i-1];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            fresh <= 1'b0;
        end else if (pxl_cen) begin
            fresh <= 1'b0;
        end else if (lk.color_step) begin
            fresh <= 1'b1;
        end
    end

    // tick aligned color capture, skipped when no lookup came back
    always_ff @(posedge clk) begin
        if (pxl_cen && (fresh || lk.color_step)) begin
            col_q <= lk.color;
        end
    end

    // output register, blanks and rgb leave together
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            lvbl_dly <= 1'b0;
            lhbl_dly <= 1'b0;
            red      <= '0;
            green    <= '0;
            blue     <= '0;
        end else if (pxl_cen) begin
            lvbl_dly <= blank_end[1];
            lhbl_dly <= blank_end[0];
            red      <= bl ? '0 : col_q.r; // black in blanking
            green    <= bl ? '0 : col_q.g;
            blue     <= bl ? '0 : col_q.b;
        end
    end

endmodule

`default_nettype wire

// ==== logic/colmix_top.sv ====
// rgb and blanks trail pixel inputs by 3 pxl_cen ticks; pxl_cen at most one clk in two
`timescale 1ns/1ns
`default_nettype none

module colmix_top import colmix_pkg::*; #(
    parameter int BLANK_STAGES = 3 // matches the pixel pipeline
) (
    input  wire logic               clk,
    input  wire logic               rst_n,
    input  wire logic               pxl_cen,
    // cpu palette bus
    input  wire logic [7:0]         cpu_din,
    input  wire logic               cpu_wr_n,
    input  wire logic [CPU_AW-1:0]  cpu_addr,
    input  wire logic               pal_cs,
    output      logic [7:0]         pal_dout,
    // blanking
    input  wire logic               vbl,
    input  wire logic               hbl,
    output      logic               lvbl_dly,
    output      logic               lhbl_dly,
    // layers
    input  wire logic [CODE_W-1:0]  char_pxl,
    input  wire logic [7:0]         obj_pxl,
    input  wire logic [7:0]         scr_pxl,
    input  wire logic [2:0]         layer_en, // char, scroll, obj
    // priority PROM programming
    input  wire logic [PRIO_AW-1:0] prog_addr,
    input  wire logic [1:0]         prom_din,
    input  wire logic               prom_we,
    // video out
    output      logic [COL_W-1:0]   red,
    output      logic [COL_W-1:0]   green,
    output      logic [COL_W-1:0]   blue
);

    pal_lookup_if lk_bus ();

    layer_priority u_prio (
        .clk        (clk),
        .rst_n      (rst_n),
        .pxl_cen    (pxl_cen),
        .char_pxl   (char_pxl),
        .obj_pxl    (obj_pxl),
        .scr_pxl    (scr_pxl),
        .layer_en   (layer_en),
        .prog_addr  (prog_addr),
        .prom_din   (prom_din),
        .prom_we    (prom_we),
        .lk         (lk_bus)
    );

    palette_store u_pal (
        .clk        (clk),
        .rst_n      (rst_n),
        .pal_cs     (pal_cs),
        .cpu_wr_n   (cpu_wr_n),
        .cpu_addr   (cpu_addr),
        .cpu_din    (cpu_din),
        .pal_dout   (pal_dout),
        .lk         (lk_bus)
    );

    color_output #(
        .BLANK_STAGES (BLANK_STAGES)
    ) u_out (
        .clk        (clk),
        .rst_n      (rst_n),
        .pxl_cen    (pxl_cen),
        .vbl        (vbl),
        .hbl        (hbl),
        .lvbl_dly   (lvbl_dly),
        .lhbl_dly   (lhbl_dly),
        .red        (red),
        .green      (green),
        .blue       (blue),
        .lk         (lk_bus)
    );

endmodule

`default_nettype wire

// ==== test/colmix_tb.sv ====
// models cover only what this testbench writes; rgb checks trail stimulus by 3 pxl_cen ticks
`timescale 1ns/1ns
`default_nettype none

module colmix_tb import colmix_pkg::*; ();

    logic              clk = 1'b0;
    logic              rst_n;
    logic              pxl_cen;
    logic [7:0]        cpu_din;
    logic              cpu_wr_n;
    logic [CPU_AW-1:0] cpu_addr;
    logic              pal_cs;
    logic              vbl;
    logic              hbl;
    logic [CODE_W-1:0] char_pxl;
    logic [7:0]        obj_pxl;
    logic [7:0]        scr_pxl;
    logic [2:0]        layer_en;
    logic [7:0]        prog_addr;
    logic [1:0]        prom_din;
    logic              prom_we;
    logic [7:0]        pal_dout;
    logic              lvbl_dly;
    logic              lhbl_dly;
    logic [3:0]        red;
    logic [3:0]        green;
    logic [3:0]        blue;

    logic [1:0]  prom_model [256];         // layer code per PROM address
    logic [11:0] pal_model [1 << PAL_AW];  // {r, g, b}
    logic [13:0] exp_q [$];                // {lvbl, lhbl, r, g, b} per tick

    colmix_top #(.BLANK_STAGES(3)) dut0 (.*);

    always #50 clk = ~clk; // 100 ns period

    task automatic stop_run(input string why);
        $display("%s", why);
        $display("Something failed");
        $fatal(1);
    endtask

    task automatic check_val(input string name, input logic [15:0] got, input logic [15:0] want);
        if (got !== want) begin
            stop_run($sformatf("ERR %s got %h expected %h", name, got, want));
        end
    endtask

    // expected outputs from enables, transparency, PROM pick, palette and blanking
    function automatic logic [13:0] ref_pixel(input logic [6:0] c, input logic [7:0] o,
                                              input logic [7:0] s, input logic [2:0] en,
                                              input logic v, input logic h);
        logic        cb;
        logic        ob;
        logic [7:0]  sg;
        logic [7:0]  sel;
        logic [8:0]  idx;
        logic [11:0] rgb;
        cb  = !en[0] || (c[3:0] == 4'd0);  // char off or transparent
        ob  = !en[2] || (o[3:0] == 4'd0);
        sg  = en[1] ? s : 8'd0;            // scroll off reads zero
        sel = {sg[7], o[7], ob, cb, sg[3:0]};
        case (prom_model[sel])
            2'd2:    idx = {2'd1, o[6:0]};
            2'd3:    idx = {2'd2, sg[6:0]};
            default: idx = {2'd0, c};      // 0 and 1 both char
        endcase
        rgb = (v || h) ? 12'h000 : pal_model[idx];
        return {~v, ~h, rgb};
    endfunction

    // cpu readback as g:r byte or blue under ones
    function automatic logic [7:0] expected_dout(input logic [CPU_AW-1:0] a);
        logic [11:0] m;
        m = pal_model[a[8:0]];
        return a[9] ? {4'hf, m[3:0]} : {m[7:4], m[11:8]};
    endfunction

    task automatic pixel_tick(input logic [6:0] c, input logic [7:0] o, input logic [7:0] s,
                              input logic [2:0] en, input logic v, input logic h);
        @(posedge clk);
        #10;
        char_pxl = c;
        obj_pxl  = o;
        scr_pxl  = s;
        layer_en = en;
        vbl      = v;
        hbl      = h;
        pxl_cen  = 1'b1;
        exp_q.push_back(ref_pixel(c, o, s, en, v, h));
        @(posedge clk);
        #10;
        pxl_cen = 1'b0; // one clk in two
    endtask

    task automatic random_tick(input logic [2:0] en, input logic v, input logic h);
        pixel_tick(7'($urandom), 8'($urandom), 8'($urandom), en, v, h);
    endtask

    task automatic blank_ticks(input int n);
        for (int i = 0; i < n; i++) begin
            pixel_tick(7'd0, 8'd0, 8'd0, 3'b111, 1'b1, 1'b1);
        end
    endtask

    task automatic program_prom();
        for (int a = 0; a < 256; a++) begin
            @(posedge clk);
            #10;
            prog_addr     = 8'(a);
            prom_din      = 2'($urandom);
            prom_we       = 1'b1;
            prom_model[a] = prom_din;
        end
        @(posedge clk);
        #10;
        prom_we = 1'b0;
    endtask

    // holds the bus 4 clk and samples readback 3 clk in
    task automatic cpu_access(input logic [CPU_AW-1:0] a, input logic [7:0] d, input logic wr,
                              output logic [7:0] dout);
        @(posedge clk);
        #10;
        pal_cs   = 1'b1;
        cpu_wr_n = ~wr;
        cpu_addr = a;
        cpu_din  = d;
        repeat (3) @(posedge clk);
        #10;
        dout = pal_dout;
        @(posedge clk);
        #10;
        pal_cs   = 1'b0;
        cpu_wr_n = 1'b1;
        if (wr && a[9]) begin
            pal_model[a[8:0]][3:0] = d[3:0];               // blue nibble
        end else if (wr) begin
            pal_model[a[8:0]][11:4] = {d[3:0], d[7:4]};    // r from the low nibble
        end
    endtask

    // output of tick n lands after tick n+3
    always begin : compare_outputs
        logic [13:0] e;
        @(posedge clk);
        if (rst_n === 1'b1 && pxl_cen === 1'b1) begin
            @(negedge clk);
            if (exp_q.size() > 3) begin
                e = exp_q.pop_front();
                check_val("lvbl_dly", 16'(lvbl_dly), 16'(e[13]));
                check_val("lhbl_dly", 16'(lhbl_dly), 16'(e[12]));
                check_val("red", 16'(red), 16'(e[11:8]));
                check_val("green", 16'(green), 16'(e[7:4]));
                check_val("blue", 16'(blue), 16'(e[3:0]));
            end
        end
    end

    initial begin
        logic [7:0]        dout;
        logic [CPU_AW-1:0] a;
        logic [2:0]        en;
        int                waited;
        void'($urandom(59)); // one seed for the whole run
        rst_n     = 1'b0;
        pxl_cen   = 1'b0;
        cpu_din   = 8'd0;
        cpu_wr_n  = 1'b1;
        cpu_addr  = '0;
        pal_cs    = 1'b0;
        vbl       = 1'b1;
        hbl       = 1'b1;
        char_pxl  = '0;
        obj_pxl   = 8'd0;
        scr_pxl   = 8'd0;
        layer_en  = 3'b111;
        prog_addr = 8'd0;
        prom_din  = 2'd0;
        prom_we   = 1'b0;
        repeat (3) @(posedge clk);
        #10;
        rst_n = 1'b1;
        @(negedge clk);
        check_val("red", 16'(red), 16'h0);
        check_val("green", 16'(green), 16'h0);
        check_val("blue", 16'(blue), 16'h0);
        check_val("lvbl_dly", 16'(lvbl_dly), 16'h0);
        check_val("lhbl_dly", 16'(lhbl_dly), 16'h0);
        program_prom();
        for (int i = 0; i < 1024; i++) begin
            cpu_access(10'(i), 8'($urandom), 1'b1, dout); // whole palette in both halves
        end
        for (int i = 0; i < 48; i++) begin
            a = 10'($urandom);
            cpu_access(a, 8'($urandom), 1'b1, dout);
            cpu_access(a, 8'h00, 1'b0, dout);
            check_val("pal_dout", 16'(dout), 16'(expected_dout(a)));
        end
        blank_ticks(4);
        for (int i = 0; i < 300; i++) begin
            random_tick(3'b111, 1'b0, 1'b0);
        end
        for (int k = 0; k < 3; k++) begin
            en = 3'b111 & ~(3'b001 << k); // one layer off at a time
            for (int i = 0; i < 120; i++) begin
                random_tick(en, 1'b0, 1'b0);
            end
        end
        for (int i = 0; i < 200; i++) begin
            random_tick(3'b111, ($urandom % 4) == 0, ($urandom % 4) == 0);
        end
        waited = 0;
        while (!(lvbl_dly === 1'b1 && lhbl_dly === 1'b1)) begin
            if (waited == 8) begin
                stop_run("blanking outputs did not go inactive after blanking ended");
            end else begin
                random_tick(3'b111, 1'b0, 1'b0);
                waited++;
            end
        end
        blank_ticks(4);
        for (int i = 0; i < 16; i++) begin
            cpu_access(10'($urandom), 8'($urandom), 1'b1, dout); // palette rewrite mid run
        end
        for (int i = 0; i < 100; i++) begin
            random_tick(3'b111, 1'b0, 1'b0);
        end
        blank_ticks(4);
        $display("Everything OK");
        $finish;
    end

endmodule

`default_nettype wire

// ==== all.f ====
logic/colmix_pkg.sv
logic/pal_lookup_if.sv
logic/sync_ram.sv
logic/layer_priority.sv
logic/palette_store.sv
logic/color_output.sv
logic/colmix_top.sv
test/colmix_tb.sv

// ==== Makefile ====
# Verilator build and run of the color mixer testbench

LOG := sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, report pass or fail"
	@echo "  clean  remove the build folder and the log"
	@echo "  help   this list"

test:
	verilator --binary --timing -f all.f --top-module colmix_tb -Mdir obj_dir -o colmix_sim
	-./obj_dir/colmix_sim > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "Something failed" $(LOG); then echo "TEST FAILED"; exit 1; fi
	@if ! grep -q "Everything OK" $(LOG); then echo "TEST FAILED, no result"; exit 1; fi
	@echo "TEST PASSED"

clean:
	rm -rf obj_dir $(LOG)
